//--- Makefile
# Verilator build and run for the processor testbench

VERILATOR ?= verilator
TOP       ?= tb_processor
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- cpu_pkg.sv
// shared definitions for the five-stage core
// widths, word typedefs, operand-source enum
// primary opcodes, alu function codes and instruction field positions
`default_nettype none

package cpu_pkg;
    localparam int WORD_W = 32;
    localparam int REG_W  = 5;
    localparam int OP_W   = 5;

    typedef logic [WORD_W-1:0] word_t;    // data or address
    typedef logic [WORD_W-1:0] insn_t;
    typedef logic [REG_W-1:0]  reg_idx_t;
    typedef logic [OP_W-1:0]   opcode_t;
    typedef logic [OP_W-1:0]   alu_op_t;

    // where execute takes an operand from
    typedef enum logic [1:0] {FWD_RF, FWD_MEM, FWD_WB} fwd_sel_t;

    localparam opcode_t OP_RTYPE = 5'd0;
    localparam opcode_t OP_J     = 5'd1;
    localparam opcode_t OP_BNE   = 5'd2;
    localparam opcode_t OP_JAL   = 5'd3;
    localparam opcode_t OP_JR    = 5'd4;
    localparam opcode_t OP_ADDI  = 5'd5;
    localparam opcode_t OP_BLT   = 5'd6;
    localparam opcode_t OP_SW    = 5'd7;
    localparam opcode_t OP_LW    = 5'd8;

    // r-type function field
    localparam alu_op_t ALU_ADD = 5'd0;
    localparam alu_op_t ALU_SUB = 5'd1;
    localparam alu_op_t ALU_AND = 5'd2;
    localparam alu_op_t ALU_OR  = 5'd3;
    localparam alu_op_t ALU_SLL = 5'd4;
    localparam alu_op_t ALU_SRA = 5'd5;

    localparam int OPC_HI   = 31;
    localparam int OPC_LO   = 27;
    localparam int RD_HI    = 26;
    localparam int RD_LO    = 22;
    localparam int RS_HI    = 21;
    localparam int RS_LO    = 17;
    localparam int RT_HI    = 16;
    localparam int RT_LO    = 12;
    localparam int SHAMT_HI = 11;
    localparam int SHAMT_LO = 7;
    localparam int FUNC_HI  = 6;
    localparam int FUNC_LO  = 2;
    localparam int IMM_HI   = 16;   // sign bit of immediate
    localparam int IMM_LO   = 0;
    localparam int TGT_HI   = 26;   // sign bit of jump target
    localparam int TGT_LO   = 0;

    localparam reg_idx_t LINK_REG = 5'd31;   // jal destination
    localparam insn_t    NOP_INSN = '0;      // add r0, r0, r0
endpackage

`default_nettype wire

//--- decode_stage.sv
// decode stage
// register read selection, writeback bypass into decode
// immediate extension and the decode/execute register
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              stall,
    input  logic              flush,
    input  cpu_pkg::insn_t    fd_insn,
    input  cpu_pkg::word_t    fd_pc_next,
    input  cpu_pkg::word_t    data_readRegA,
    input  cpu_pkg::word_t    data_readRegB,
    input  logic              wb_fwd_a,
    input  logic              wb_fwd_b,
    input  cpu_pkg::word_t    data_writeReg,
    output cpu_pkg::reg_idx_t ctrl_readRegA,
    output cpu_pkg::reg_idx_t ctrl_readRegB,
    output cpu_pkg::insn_t    dx_insn,
    output cpu_pkg::word_t    dx_pc_next,
    output cpu_pkg::word_t    dx_a,
    output cpu_pkg::word_t    dx_b,
    output cpu_pkg::word_t    dx_imm,
    output cpu_pkg::reg_idx_t dx_src_a,
    output cpu_pkg::reg_idx_t dx_src_b
);
    import cpu_pkg::*;

    opcode_t  opcode;
    logic     is_branch;
    logic     reads_rd_b;   // sw data and jr target sit in rd
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    word_t    a_val;
    word_t    b_val;
    word_t    imm_ext;

    assign opcode     = fd_insn[OPC_HI:OPC_LO];
    assign rd         = fd_insn[RD_HI:RD_LO];
    assign rs         = fd_insn[RS_HI:RS_LO];
    assign rt         = fd_insn[RT_HI:RT_LO];
    assign is_branch  = (opcode == OP_BNE) || (opcode == OP_BLT);
    assign reads_rd_b = (opcode == OP_SW) || (opcode == OP_JR);

    // branches compare rd against rs
    assign ctrl_readRegA = is_branch ? rd : rs;
    assign ctrl_readRegB = is_branch ? rs : (reads_rd_b ? rd : rt);

    // same-cycle writeback would be missed by the register file read
    assign a_val   = wb_fwd_a ? data_writeReg : data_readRegA;
    assign b_val   = wb_fwd_b ? data_writeReg : data_readRegB;
    assign imm_ext = {{(WORD_W-IMM_HI-1){fd_insn[IMM_HI]}}, fd_insn[IMM_HI:IMM_LO]};

    always_ff @(posedge clock) begin
        if (!rst_n || stall || flush) begin
            dx_insn  <= NOP_INSN;         // bubble into execute
            dx_src_a <= '0;
            dx_src_b <= '0;
        end else begin
            dx_insn  <= fd_insn;
            dx_src_a <= ctrl_readRegA;    // kept for forwarding compares
            dx_src_b <= ctrl_readRegB;
        end
    end

    always_ff @(posedge clock) begin
        dx_pc_next <= fd_pc_next;
        dx_a       <= a_val;
        dx_b       <= b_val;
        dx_imm     <= imm_ext;
    end
endmodule

`default_nettype wire

//--- execute_stage.sv
// execute stage
// operand forwarding muxes, alu, branch and jump resolution
// and the execute/memory register
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  logic              clock,
    input  logic              rst_n,
    input  cpu_pkg::insn_t    dx_insn,
    input  cpu_pkg::word_t    dx_pc_next,
    input  cpu_pkg::word_t    dx_a,
    input  cpu_pkg::word_t    dx_b,
    input  cpu_pkg::word_t    dx_imm,
    input  cpu_pkg::fwd_sel_t fwd_a,
    input  cpu_pkg::fwd_sel_t fwd_b,
    input  cpu_pkg::word_t    xm_value,
    input  cpu_pkg::word_t    wb_value,
    output logic              redirect,
    output cpu_pkg::word_t    redirect_pc,
    output cpu_pkg::insn_t    xm_insn,
    output cpu_pkg::word_t    xm_result,
    output cpu_pkg::word_t    xm_store_data
);
    import cpu_pkg::*;

    opcode_t                      opcode;
    alu_op_t                      alu_op;
    logic [SHAMT_HI-SHAMT_LO:0]   shamt;
    logic                         uses_imm;   // addi, lw, sw
    logic                         is_jal;
    logic                         is_jump;
    logic                         taken;
    word_t                        op_a;
    word_t                        op_b;
    word_t                        alu_b;
    word_t                        alu_out;
    word_t                        br_target;
    word_t                        jmp_target;

    function automatic word_t pick_operand(input fwd_sel_t sel, input word_t rf,
                                           input word_t mem, input word_t wb);
        word_t val;
        case (sel)
            FWD_MEM: val = mem;
            FWD_WB:  val = wb;
            default: val = rf;
        endcase
        return val;
    endfunction

    assign op_a = pick_operand(fwd_a, dx_a, xm_value, wb_value);
    assign op_b = pick_operand(fwd_b, dx_b, xm_value, wb_value);

    assign opcode   = dx_insn[OPC_HI:OPC_LO];
    assign shamt    = dx_insn[SHAMT_HI:SHAMT_LO];
    assign uses_imm = (opcode == OP_ADDI) || (opcode == OP_LW) || (opcode == OP_SW);
    assign alu_op   = (opcode == OP_RTYPE) ? dx_insn[FUNC_HI:FUNC_LO] : ALU_ADD;
    assign alu_b    = uses_imm ? dx_imm : op_b;

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_out = op_a + alu_b;
            ALU_SUB: alu_out = op_a - alu_b;
            ALU_AND: alu_out = op_a & alu_b;
            ALU_OR:  alu_out = op_a | alu_b;
            ALU_SLL: alu_out = op_a << shamt;
            ALU_SRA: alu_out = word_t'($signed(op_a) >>> shamt);
            default: alu_out = '0;          // unused function codes
        endcase
    end

    // bne/blt compare rd (a) with rs (b)
    assign taken = ((opcode == OP_BNE) && (op_a != op_b))
                   || ((opcode == OP_BLT) && ($signed(op_a) < $signed(op_b)));

    assign is_jal     = (opcode == OP_JAL);
    assign is_jump    = (opcode == OP_J) || is_jal || (opcode == OP_JR);
    assign br_target  = dx_pc_next + dx_imm;
    assign jmp_target = (opcode == OP_JR) ? op_b      // jr target comes through rd
                        : {{(WORD_W-TGT_HI-1){dx_insn[TGT_HI]}}, dx_insn[TGT_HI:TGT_LO]};

    assign redirect    = taken || is_jump;
    assign redirect_pc = taken ? br_target : jmp_target;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            xm_insn <= NOP_INSN;
        end else begin
            xm_insn <= dx_insn;
        end
    end

    always_ff @(posedge clock) begin
        xm_result     <= is_jal ? dx_pc_next : alu_out;   // jal links pc+1
        xm_store_data <= op_b;
    end
endmodule

`default_nettype wire

//--- fetch_stage.sv
// fetch stage
// program counter, next-pc choice and the fetch/decode register
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
    input  logic           clock,
    input  logic           rst_n,
    input  logic           stall,
    input  logic           redirect,
    input  cpu_pkg::word_t redirect_pc,
    input  cpu_pkg::insn_t q_imem,
    output cpu_pkg::word_t address_imem,
    output cpu_pkg::insn_t fd_insn,
    output cpu_pkg::word_t fd_pc_next
);
    import cpu_pkg::*;

    word_t pc;
    word_t pc_plus1;

    assign pc_plus1     = pc + 32'd1;   // word addressed memory
    assign address_imem = pc;

    // redirect from execute wins over a load-use hold
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc_plus1;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            fd_insn <= NOP_INSN;
        end else if (redirect) begin
            fd_insn <= NOP_INSN;          // squash the wrong-path fetch
        end else if (!stall) begin
            fd_insn <= q_imem;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            fd_pc_next <= pc_plus1;       // link value and branch base
        end
    end
endmodule

`default_nettype wire

//--- hazard_unit.sv
// hazard detection
// execute operand forwarding selects, writeback bypass flags for decode
// load-use stall and branch/jump flush
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
    input  cpu_pkg::reg_idx_t ctrl_readRegA,
    input  cpu_pkg::reg_idx_t ctrl_readRegB,
    input  cpu_pkg::reg_idx_t dx_src_a,
    input  cpu_pkg::reg_idx_t dx_src_b,
    input  cpu_pkg::insn_t    dx_insn,
    input  cpu_pkg::reg_idx_t xm_dest,
    input  logic              xm_writes,
    input  cpu_pkg::reg_idx_t wb_dest,
    input  logic              wb_writes,
    input  logic              redirect,
    output logic              stall,
    output logic              flush,
    output logic              wb_fwd_a,
    output logic              wb_fwd_b,
    output cpu_pkg::fwd_sel_t fwd_a,
    output cpu_pkg::fwd_sel_t fwd_b
);
    import cpu_pkg::*;

    reg_idx_t dx_rd;
    logic     dx_is_load;

    // write flags are already low for r0 so r0 never matches
    // the younger producer in memory wins over writeback
    function automatic fwd_sel_t pick_fwd(input reg_idx_t src, input reg_idx_t m_dest,
                                          input logic m_wr, input reg_idx_t w_dest,
                                          input logic w_wr);
        fwd_sel_t sel;
        sel = FWD_RF;
        if (m_wr && src == m_dest) begin
            sel = FWD_MEM;
        end else if (w_wr && src == w_dest) begin
            sel = FWD_WB;
        end
        return sel;
    endfunction

    assign fwd_a = pick_fwd(dx_src_a, xm_dest, xm_writes, wb_dest, wb_writes);
    assign fwd_b = pick_fwd(dx_src_b, xm_dest, xm_writes, wb_dest, wb_writes);

    assign wb_fwd_a = wb_writes && (ctrl_readRegA == wb_dest);
    assign wb_fwd_b = wb_writes && (ctrl_readRegB == wb_dest);

    // loaded word only exists after memory, so hold decode one cycle
    assign dx_rd      = dx_insn[RD_HI:RD_LO];
    assign dx_is_load = (dx_insn[OPC_HI:OPC_LO] == OP_LW);
    assign stall      = dx_is_load && (dx_rd != '0)
                        && ((dx_rd == ctrl_readRegA) || (dx_rd == ctrl_readRegB));

    assign flush = redirect;   // kills the instruction in decode
endmodule

`default_nettype wire

//--- list.f
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
hazard_unit.sv
execute_stage.sv
mem_wb_stage.sv
processor.sv
tb_processor.sv

//--- mem_wb_stage.sv
// memory and writeback stages
// data memory drive, destination decode, memory/writeback register
// and writeback value select
`timescale 1ns/1ns
`default_nettype none

module mem_wb_stage (
    input  logic              clock,
    input  logic              rst_n,
    input  cpu_pkg::insn_t    xm_insn,
    input  cpu_pkg::word_t    xm_result,
    input  cpu_pkg::word_t    xm_store_data,
    input  cpu_pkg::word_t    q_dmem,
    output cpu_pkg::word_t    address_dmem,
    output cpu_pkg::word_t    data,
    output logic              wren,
    output cpu_pkg::reg_idx_t xm_dest,
    output logic              xm_writes,
    output cpu_pkg::word_t    xm_value,
    output logic              ctrl_writeEnable,
    output cpu_pkg::reg_idx_t ctrl_writeReg,
    output cpu_pkg::word_t    data_writeReg
);
    import cpu_pkg::*;

    opcode_t  opcode;
    logic     is_load;
    logic     mw_load;
    logic     mw_writes;
    reg_idx_t mw_dest;
    word_t    mw_result;
    word_t    mw_loaded;

    assign opcode  = xm_insn[OPC_HI:OPC_LO];
    assign is_load = (opcode == OP_LW);

    // memory answers in the same cycle
    assign address_dmem = xm_result;
    assign data         = xm_store_data;
    assign wren         = (opcode == OP_SW);

    assign xm_dest   = (opcode == OP_JAL) ? LINK_REG : xm_insn[RD_HI:RD_LO];
    assign xm_writes = ((opcode == OP_RTYPE) || (opcode == OP_ADDI) || is_load
                        || (opcode == OP_JAL)) && (xm_dest != '0);   // r0 stays zero
    assign xm_value  = xm_result;   // not valid for lw, the stall covers that

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            mw_writes <= 1'b0;
            mw_load   <= 1'b0;
            mw_dest   <= '0;
        end else begin
            mw_writes <= xm_writes;
            mw_load   <= is_load;
            mw_dest   <= xm_dest;
        end
    end

    always_ff @(posedge clock) begin
        mw_result <= xm_result;
        mw_loaded <= q_dmem;
    end

    assign ctrl_writeEnable = mw_writes;
    assign ctrl_writeReg    = mw_dest;
    assign data_writeReg    = mw_load ? mw_loaded : mw_result;
endmodule

`default_nettype wire

//--- processor.sv
// five-stage pipelined processor top
// stage and hazard unit wiring to the external memories and register file
`timescale 1ns/1ns
`default_nettype none

module processor (
    input  logic              clock,
    input  logic              rst_n,
    output cpu_pkg::word_t    address_imem,
    input  cpu_pkg::insn_t    q_imem,
    output cpu_pkg::word_t    address_dmem,
    output cpu_pkg::word_t    data,
    output logic              wren,
    input  cpu_pkg::word_t    q_dmem,
    output logic              ctrl_writeEnable,
    output cpu_pkg::reg_idx_t ctrl_writeReg,
    output cpu_pkg::reg_idx_t ctrl_readRegA,
    output cpu_pkg::reg_idx_t ctrl_readRegB,
    output cpu_pkg::word_t    data_writeReg,
    input  cpu_pkg::word_t    data_readRegA,
    input  cpu_pkg::word_t    data_readRegB
);
    import cpu_pkg::*;

    insn_t    fd_insn;
    word_t    fd_pc_next;
    logic     stall;
    logic     flush;
    logic     redirect;
    word_t    redirect_pc;
    logic     wb_fwd_a;
    logic     wb_fwd_b;
    insn_t    dx_insn;
    word_t    dx_pc_next;
    word_t    dx_a;
    word_t    dx_b;
    word_t    dx_imm;
    reg_idx_t dx_src_a;
    reg_idx_t dx_src_b;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    insn_t    xm_insn;
    word_t    xm_result;
    word_t    xm_store_data;
    reg_idx_t xm_dest;
    logic     xm_writes;
    word_t    xm_value;

    fetch_stage fetch_i (
        .clock(clock), .rst_n(rst_n), .stall(stall), .redirect(redirect),
        .redirect_pc(redirect_pc), .q_imem(q_imem), .address_imem(address_imem),
        .fd_insn(fd_insn), .fd_pc_next(fd_pc_next)
    );

    decode_stage decode_i (
        .clock(clock), .rst_n(rst_n), .stall(stall), .flush(flush),
        .fd_insn(fd_insn), .fd_pc_next(fd_pc_next),
        .data_readRegA(data_readRegA), .data_readRegB(data_readRegB),
        .wb_fwd_a(wb_fwd_a), .wb_fwd_b(wb_fwd_b), .data_writeReg(data_writeReg),
        .ctrl_readRegA(ctrl_readRegA), .ctrl_readRegB(ctrl_readRegB),
        .dx_insn(dx_insn), .dx_pc_next(dx_pc_next), .dx_a(dx_a), .dx_b(dx_b),
        .dx_imm(dx_imm), .dx_src_a(dx_src_a), .dx_src_b(dx_src_b)
    );

    // writeback side comes straight off the register file ports
    hazard_unit hazard_i (
        .ctrl_readRegA(ctrl_readRegA), .ctrl_readRegB(ctrl_readRegB),
        .dx_src_a(dx_src_a), .dx_src_b(dx_src_b), .dx_insn(dx_insn),
        .xm_dest(xm_dest), .xm_writes(xm_writes),
        .wb_dest(ctrl_writeReg), .wb_writes(ctrl_writeEnable), .redirect(redirect),
        .stall(stall), .flush(flush), .wb_fwd_a(wb_fwd_a), .wb_fwd_b(wb_fwd_b),
        .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    execute_stage execute_i (
        .clock(clock), .rst_n(rst_n), .dx_insn(dx_insn), .dx_pc_next(dx_pc_next),
        .dx_a(dx_a), .dx_b(dx_b), .dx_imm(dx_imm), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .xm_value(xm_value), .wb_value(data_writeReg),
        .redirect(redirect), .redirect_pc(redirect_pc), .xm_insn(xm_insn),
        .xm_result(xm_result), .xm_store_data(xm_store_data)
    );

    mem_wb_stage mem_wb_i (
        .clock(clock), .rst_n(rst_n), .xm_insn(xm_insn), .xm_result(xm_result),
        .xm_store_data(xm_store_data), .q_dmem(q_dmem),
        .address_dmem(address_dmem), .data(data), .wren(wren),
        .xm_dest(xm_dest), .xm_writes(xm_writes), .xm_value(xm_value),
        .ctrl_writeEnable(ctrl_writeEnable), .ctrl_writeReg(ctrl_writeReg),
        .data_writeReg(data_writeReg)
    );
endmodule

`default_nettype wire

//--- tb_processor.sv
// testbench for the five-stage processor
// instruction rom, data memory and register file models
// program table, expected writeback and store tables, checkers and timeout
`timescale 1ns/1ns
`default_nettype none

module tb_processor;
    import cpu_pkg::*;

    localparam int ROM_DEPTH    = 32;
    localparam int DMEM_DEPTH   = 256;
    localparam int DRAIN_CYCLES = 20;    // watch for stray writes after the last one

    logic     clock;
    logic     rst_n;
    word_t    address_imem;
    insn_t    q_imem;
    word_t    address_dmem;
    word_t    data;
    logic     wren;
    word_t    q_dmem;
    logic     ctrl_writeEnable;
    reg_idx_t ctrl_writeReg;
    reg_idx_t ctrl_readRegA;
    reg_idx_t ctrl_readRegB;
    word_t    data_writeReg;
    word_t    data_readRegA;
    word_t    data_readRegB;

    insn_t    program_rom [ROM_DEPTH];
    word_t    dmem [DMEM_DEPTH];
    word_t    regs [32];
    reg_idx_t exp_dest [$];              // expected writebacks in program order
    word_t    exp_value [$];
    word_t    st_addr [$];               // expected stores in program order
    word_t    st_data [$];
    int       exp_idx;
    int       st_idx;
    int       errors;
    int       cycles;
    int       limit;

    processor processor_i (
        .clock(clock), .rst_n(rst_n),
        .address_imem(address_imem), .q_imem(q_imem),
        .address_dmem(address_dmem), .data(data), .wren(wren), .q_dmem(q_dmem),
        .ctrl_writeEnable(ctrl_writeEnable), .ctrl_writeReg(ctrl_writeReg),
        .ctrl_readRegA(ctrl_readRegA), .ctrl_readRegB(ctrl_readRegB),
        .data_writeReg(data_writeReg),
        .data_readRegA(data_readRegA), .data_readRegB(data_readRegB)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;      // 20 ns period
    end

    // memories and register file answer in the same cycle
    assign q_imem        = (address_imem[31:5] == '0) ? program_rom[address_imem[4:0]]
                                                      : NOP_INSN;
    assign q_dmem        = dmem[address_dmem[7:0]];
    assign data_readRegA = regs[ctrl_readRegA];
    assign data_readRegB = regs[ctrl_readRegB];

    always @(posedge clock) begin
        if (wren) begin
            dmem[address_dmem[7:0]] <= data;
        end
        if (ctrl_writeEnable && ctrl_writeReg != 5'd0) begin
            regs[ctrl_writeReg] <= data_writeReg;    // r0 stays zero
        end
    end

    function automatic insn_t rtype_word(input reg_idx_t rd, input reg_idx_t rs,
                                         input reg_idx_t rt, input logic [4:0] shamt,
                                         input alu_op_t fn);
        return {OP_RTYPE, rd, rs, rt, shamt, fn, 2'b00};
    endfunction

    function automatic insn_t imm_word(input opcode_t op, input reg_idx_t rd,
                                       input reg_idx_t rs, input logic [16:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic insn_t jump_word(input opcode_t op, input logic [26:0] target);
        return {op, target};
    endfunction

    task automatic load_program();
        program_rom[0]  = imm_word(OP_ADDI, 5'd1, 5'd0, 17'd12);
        program_rom[1]  = imm_word(OP_ADDI, 5'd2, 5'd1, 17'h1FFFE);     // -2
        program_rom[2]  = rtype_word(5'd3, 5'd1, 5'd2, 5'd0, ALU_ADD);
        program_rom[3]  = rtype_word(5'd4, 5'd3, 5'd1, 5'd0, ALU_SUB);
        program_rom[4]  = rtype_word(5'd5, 5'd3, 5'd4, 5'd0, ALU_AND);
        program_rom[5]  = rtype_word(5'd6, 5'd5, 5'd1, 5'd0, ALU_OR);
        program_rom[6]  = rtype_word(5'd7, 5'd6, 5'd0, 5'd4, ALU_SLL);
        program_rom[7]  = rtype_word(5'd8, 5'd0, 5'd7, 5'd0, ALU_SUB);  // negative
        program_rom[8]  = rtype_word(5'd9, 5'd8, 5'd0, 5'd2, ALU_SRA);
        program_rom[9]  = imm_word(OP_ADDI, 5'd10, 5'd0, 17'd20);     // base address
        program_rom[10] = imm_word(OP_SW, 5'd9, 5'd10, 17'd3);
        program_rom[11] = imm_word(OP_LW, 5'd11, 5'd10, 17'd3);
        program_rom[12] = rtype_word(5'd12, 5'd11, 5'd1, 5'd0, ALU_ADD); // load-use
        program_rom[13] = imm_word(OP_BNE, 5'd1, 5'd2, 17'd2);         // taken to 16
        program_rom[14] = imm_word(OP_ADDI, 5'd13, 5'd0, 17'd1);
        program_rom[15] = imm_word(OP_ADDI, 5'd13, 5'd0, 17'd2);
        program_rom[16] = imm_word(OP_BLT, 5'd8, 5'd1, 17'd2);         // taken to 19
        program_rom[17] = imm_word(OP_ADDI, 5'd14, 5'd0, 17'd3);
        program_rom[18] = imm_word(OP_ADDI, 5'd14, 5'd0, 17'd4);
        program_rom[19] = imm_word(OP_BNE, 5'd4, 5'd2, 17'd1);         // operands equal
        program_rom[20] = imm_word(OP_ADDI, 5'd15, 5'd0, 17'd7);
        program_rom[21] = imm_word(OP_BLT, 5'd1, 5'd8, 17'd1);         // 12 < -224 is false
        program_rom[22] = imm_word(OP_ADDI, 5'd16, 5'd15, 17'd9);
        program_rom[23] = jump_word(OP_JAL, 27'd26);
        program_rom[24] = imm_word(OP_ADDI, 5'd17, 5'd0, 17'h55);      // return point
        program_rom[25] = jump_word(OP_J, 27'd29);
        program_rom[26] = imm_word(OP_ADDI, 5'd18, 5'd0, 17'h66);      // subroutine
        program_rom[27] = imm_word(OP_JR, 5'd31, 5'd0, 17'd0);
        program_rom[28] = imm_word(OP_ADDI, 5'd19, 5'd0, 17'd1);       // never runs
        program_rom[29] = rtype_word(5'd20, 5'd17, 5'd18, 5'd0, ALU_ADD);
        program_rom[30] = imm_word(OP_LW, 5'd21, 5'd10, 17'd3);
        program_rom[31] = jump_word(OP_J, 27'd31);                     // park here
    endtask

    task automatic expect_write(input reg_idx_t dest, input word_t value);
        exp_dest.push_back(dest);
        exp_value.push_back(value);
    endtask

    task automatic expect_store(input word_t addr, input word_t value);
        st_addr.push_back(addr);
        st_data.push_back(value);
    endtask

    // worked out by hand from the instruction rules
    task automatic load_expected();
        expect_write(5'd1, 32'h0000000C);
        expect_write(5'd2, 32'h0000000A);
        expect_write(5'd3, 32'h00000016);
        expect_write(5'd4, 32'h0000000A);
        expect_write(5'd5, 32'h00000002);
        expect_write(5'd6, 32'h0000000E);
        expect_write(5'd7, 32'h000000E0);
        expect_write(5'd8, 32'hFFFFFF20);
        expect_write(5'd9, 32'hFFFFFFC8);
        expect_write(5'd10, 32'h00000014);
        expect_write(5'd11, 32'hFFFFFFC8);   // stored word comes back
        expect_write(5'd12, 32'hFFFFFFD4);
        expect_write(5'd15, 32'h00000007);
        expect_write(5'd16, 32'h00000010);
        expect_write(5'd31, 32'h00000018);   // jal at 23 links 24
        expect_write(5'd18, 32'h00000066);
        expect_write(5'd17, 32'h00000055);
        expect_write(5'd20, 32'h000000BB);
        expect_write(5'd21, 32'hFFFFFFC8);
        expect_store(32'h00000017, 32'hFFFFFFC8);   // sw r9 to 20 + 3
    endtask

    task automatic clear_state();
        int i;
        for (i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (i = 0; i < DMEM_DEPTH; i++) begin
            dmem[i] = {24'hDA7A00, i[7:0]};    // address tagged fill
        end
    endtask

    // nothing reaches memory or writeback in the first four cycles out of reset
    task automatic check_idle_start();
        int i;
        for (i = 0; i < 4; i++) begin
            @(negedge clock);
            if (i == 0 && address_imem !== 32'h0) begin
                errors = errors + 1;
                $display("CHECK FAILED address_imem: expected 0x%h, got 0x%h", 32'h0,
                         address_imem);
            end
            if (wren !== 1'b0) begin
                errors = errors + 1;
                $display("CHECK FAILED wren in cycle %0d: expected 0x0, got 0x%h", i, wren);
            end
            if (ctrl_writeEnable !== 1'b0) begin
                errors = errors + 1;
                $display("CHECK FAILED ctrl_writeEnable in cycle %0d: expected 0x0, got 0x%h",
                         i, ctrl_writeEnable);
            end
        end
    endtask

    // writeback outputs are registered, so mid-cycle they are settled
    always @(negedge clock) begin
        if (rst_n && ctrl_writeEnable) begin
            if (exp_idx >= exp_dest.size()) begin
                errors = errors + 1;
                $display("register r%0d was written after the last expected writeback",
                         ctrl_writeReg);
            end else begin
                if (ctrl_writeReg !== exp_dest[exp_idx]) begin
                    errors = errors + 1;
                    $display("CHECK FAILED ctrl_writeReg at write %0d: expected 0x%h, got 0x%h",
                             exp_idx, exp_dest[exp_idx], ctrl_writeReg);
                end
                if (data_writeReg !== exp_value[exp_idx]) begin
                    errors = errors + 1;
                    $display("CHECK FAILED data_writeReg at write %0d: expected 0x%h, got 0x%h",
                             exp_idx, exp_value[exp_idx], data_writeReg);
                end
                exp_idx = exp_idx + 1;
            end
        end
    end

    // stores leave through the data memory port in program order
    always @(negedge clock) begin
        if (rst_n && wren) begin
            if (st_idx >= st_addr.size()) begin
                errors = errors + 1;
                $display("unexpected store to data address 0x%h", address_dmem);
            end else begin
                if (address_dmem !== st_addr[st_idx]) begin
                    errors = errors + 1;
                    $display("CHECK FAILED address_dmem at store %0d: expected 0x%h, got 0x%h",
                             st_idx, st_addr[st_idx], address_dmem);
                end
                if (data !== st_data[st_idx]) begin
                    errors = errors + 1;
                    $display("CHECK FAILED data at store %0d: expected 0x%h, got 0x%h",
                             st_idx, st_data[st_idx], data);
                end
                st_idx = st_idx + 1;
            end
        end
    end

    initial begin
        rst_n   = 1'b0;
        exp_idx = 0;
        st_idx  = 0;
        errors  = 0;
        cycles  = 0;
        load_program();
        load_expected();
        clear_state();
        limit = exp_dest.size() * 6 + 50;
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;
        check_idle_start();
        while (exp_idx < exp_dest.size() && cycles < limit) begin
            @(posedge clock);
            cycles = cycles + 1;
        end
        if (exp_idx < exp_dest.size()) begin
            errors = errors + 1;
            $display("timeout after %0d cycles, only %0d of %0d writebacks seen",
                     cycles, exp_idx, exp_dest.size());
        end
        repeat (DRAIN_CYCLES) @(posedge clock);
        if (st_idx < st_addr.size()) begin
            errors = errors + 1;
            $display("only %0d of %0d expected stores reached the data memory",
                     st_idx, st_addr.size());
        end
        $display("writebacks seen %0d of %0d, stores seen %0d of %0d, errors %0d",
                 exp_idx, exp_dest.size(), st_idx, st_addr.size(), errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end
endmodule

`default_nettype wire
